// ==== common/ooo_isa_pkg.sv ====
package ooo_isa_pkg;

    localparam int ARCH_REG_SZ = 8;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LI,
        OP_HALT
    } opcode_e;

    typedef enum logic {
        NO_ERROR,
        HALTED
    } exc_e;

    typedef logic [2:0]  arn_t;
    typedef logic [31:0] data_t;
    // zero-extended by the alu
    typedef logic [15:0] imm_t;

endpackage

// ==== common/ooo_core_pkg.sv ====
package ooo_core_pkg;

    import ooo_isa_pkg::*;

    localparam int PHYS_REG_SZ = 16;

    typedef logic [3:0] prn_t;

    // wide enough for the largest buffer of 8 entries
    typedef logic [2:0] robn_t;

    typedef struct packed {
        arn_t arn;
        prn_t prn;
        logic complete;
        logic halt;
    } rob_entry_t;

endpackage

// ==== common/ooo_ifs.sv ====
`timescale 1ns/1ps

// rs to alu, no ready since the alu takes one per cycle
interface issue_if
    import ooo_isa_pkg::*, ooo_core_pkg::*;
();
    logic    valid;
    opcode_e op;
    data_t   opa;
    data_t   opb;
    imm_t    imm;
    prn_t    dest_prn;
    robn_t   robn;

    modport source (output valid, op, opa, opb, imm, dest_prn, robn);
    modport sink (input valid, op, opa, opb, imm, dest_prn, robn);
endinterface

interface cdb_if
    import ooo_isa_pkg::*, ooo_core_pkg::*;
();
    logic  valid;
    prn_t  prn;
    data_t value;
    robn_t robn;

    modport source (output valid, prn, value, robn);
    modport sink (input valid, prn, value, robn);
endinterface

interface retire_if
    import ooo_isa_pkg::*, ooo_core_pkg::*;
();
    logic valid;
    arn_t arn;
    prn_t prn;
    // old mapping of arn, back to the free list
    prn_t free_prn;

    modport source (output valid, arn, prn);
    modport freer (input valid, arn, prn, output free_prn);
    modport target (input valid, free_prn);
endinterface

// ==== rename/rat.sv ====
`timescale 1ns/1ps

module rat
    import ooo_isa_pkg::*, ooo_core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      rename_en,
    input  arn_t      src1,
    input  arn_t      src2,
    input  arn_t      dest,
    output prn_t      src1_prn,
    output prn_t      src2_prn,
    output prn_t      dest_prn,
    retire_if.target  retire
);

    // speculative mapping
    prn_t map [ARCH_REG_SZ];

    // circular free list, pointers wrap with prn_t
    prn_t free_list [PHYS_REG_SZ];
    prn_t head;
    prn_t tail;

    // sources see the mapping before this cycle's rename
    assign src1_prn = map[src1];
    assign src2_prn = map[src2];
    assign dest_prn = free_list[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                map[i] <= prn_t'(i);
            end
            // registers 8..15 start out free
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                free_list[i] <= prn_t'(i + ARCH_REG_SZ);
            end
            head <= '0;
            tail <= prn_t'(ARCH_REG_SZ);
        end else begin
            if (rename_en) begin
                map[dest] <= free_list[head];
                head      <= head + 1'b1;
            end
            if (retire.valid) begin
                free_list[tail] <= retire.free_prn;
                tail            <= tail + 1'b1;
            end
        end
    end

endmodule

// ==== rename/rrat.sv ====
`timescale 1ns/1ps

module rrat
    import ooo_isa_pkg::*, ooo_core_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    retire_if.freer  retire
);

    // committed mapping
    prn_t map [ARCH_REG_SZ];

    assign retire.free_prn = map[retire.arn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                map[i] <= prn_t'(i);
            end
        end else if (retire.valid) begin
            map[retire.arn] <= retire.prn;
        end
    end

endmodule

// ==== verilog/prf.sv ====
`timescale 1ns/1ps

module prf
    import ooo_isa_pkg::*, ooo_core_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  prn_t   rd_prn1,
    input  prn_t   rd_prn2,
    output data_t  rd_val1,
    output data_t  rd_val2,
    output logic   rd_rdy1,
    output logic   rd_rdy2,
    input  logic   alloc_en,
    input  prn_t   alloc_prn,
    cdb_if.sink    cdb,
    input  prn_t   ct_prn,
    output data_t  ct_val
);

    data_t                  values [PHYS_REG_SZ];
    logic [PHYS_REG_SZ-1:0] ready;

    // no bypass here, rs catches same-cycle broadcasts
    assign rd_val1 = values[rd_prn1];
    assign rd_val2 = values[rd_prn2];
    assign rd_rdy1 = ready[rd_prn1];
    assign rd_rdy2 = ready[rd_prn2];
    assign ct_val  = values[ct_prn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < ARCH_REG_SZ);
            end
        end else begin
            if (cdb.valid) begin
                values[cdb.prn] <= cdb.value;
                ready[cdb.prn]  <= 1'b1;
            end
            if (alloc_en) begin
                ready[alloc_prn] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/rs.sv ====
`timescale 1ns/1ps

module rs
    import ooo_isa_pkg::*, ooo_core_pkg::*;
#(
    parameter int RS_SZ = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_en,
    input  opcode_e  in_op,
    input  data_t    in_a,
    input  data_t    in_b,
    input  logic     in_a_rdy,
    input  logic     in_b_rdy,
    input  imm_t     in_imm,
    input  prn_t     in_dest_prn,
    input  robn_t    in_robn,
    output logic     full,
    cdb_if.sink      cdb,
    issue_if.source  issue
);

    localparam int AGE_W = (RS_SZ > 1) ? $clog2(RS_SZ) : 1;

    // operands hold a value once ready, a tag before that
    typedef struct packed {
        opcode_e op;
        data_t   a;
        logic    a_rdy;
        data_t   b;
        logic    b_rdy;
        imm_t    imm;
        prn_t    dest_prn;
        robn_t   robn;
    } slot_t;

    logic [RS_SZ-1:0] valid;
    slot_t            slots [RS_SZ];
    // 0 is oldest, ages stay a permutation of the valid slots
    logic [AGE_W-1:0] age [RS_SZ];

    logic             sel_found;
    logic [AGE_W-1:0] sel_idx;
    logic [AGE_W-1:0] free_idx;
    logic [AGE_W:0]   n_valid;
    logic [AGE_W-1:0] new_age;
    slot_t            in_slot;

    function automatic logic wakes(data_t tag, logic bus_valid, prn_t bus_prn);
        return bus_valid && (tag[$bits(prn_t)-1:0] == bus_prn);
    endfunction

    // oldest ready slot, first free slot
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        free_idx  = '0;
        n_valid   = '0;
        for (int i = RS_SZ - 1; i >= 0; i--) begin
            if (valid[i] && slots[i].a_rdy && slots[i].b_rdy &&
                (!sel_found || age[i] < age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = AGE_W'(i);
            end
            if (!valid[i]) begin
                free_idx = AGE_W'(i);
            end
            n_valid = n_valid + 1'b1 * valid[i];
        end
        new_age = AGE_W'(n_valid - sel_found);
    end

    // incoming entry, woken if its producer broadcasts right now
    always_comb begin
        in_slot.op       = in_op;
        in_slot.imm      = in_imm;
        in_slot.dest_prn = in_dest_prn;
        in_slot.robn     = in_robn;
        in_slot.a_rdy    = in_a_rdy || wakes(in_a, cdb.valid, cdb.prn);
        in_slot.a        = (!in_a_rdy && in_slot.a_rdy) ? cdb.value : in_a;
        in_slot.b_rdy    = in_b_rdy || wakes(in_b, cdb.valid, cdb.prn);
        in_slot.b        = (!in_b_rdy && in_slot.b_rdy) ? cdb.value : in_b;
    end

    assign full           = &valid;
    assign issue.valid    = sel_found;
    assign issue.op       = slots[sel_idx].op;
    assign issue.opa      = slots[sel_idx].a;
    assign issue.opb      = slots[sel_idx].b;
    assign issue.imm      = slots[sel_idx].imm;
    assign issue.dest_prn = slots[sel_idx].dest_prn;
    assign issue.robn     = slots[sel_idx].robn;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (sel_found) begin
                valid[sel_idx] <= 1'b0;
            end
            if (in_en) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SZ; i++) begin
            if (valid[i]) begin
                if (!slots[i].a_rdy && wakes(slots[i].a, cdb.valid, cdb.prn)) begin
                    slots[i].a     <= cdb.value;
                    slots[i].a_rdy <= 1'b1;
                end
                if (!slots[i].b_rdy && wakes(slots[i].b, cdb.valid, cdb.prn)) begin
                    slots[i].b     <= cdb.value;
                    slots[i].b_rdy <= 1'b1;
                end
                // close the gap left by the issued slot
                if (sel_found && age[i] > age[sel_idx]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
        end
        if (in_en) begin
            slots[free_idx] <= in_slot;
            age[free_idx]   <= new_age;
        end
    end

endmodule

// ==== verilog/alu_fu.sv ====
`timescale 1ns/1ps

module alu_fu
    import ooo_isa_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    issue_if.sink   issue,
    cdb_if.source   cdb
);

    data_t result;

    always_comb begin
        case (issue.op)
            OP_ADD:  result = issue.opa + issue.opb;
            OP_SUB:  result = issue.opa - issue.opb;
            OP_AND:  result = issue.opa & issue.opb;
            OP_OR:   result = issue.opa | issue.opb;
            OP_XOR:  result = issue.opa ^ issue.opb;
            OP_LI:   result = data_t'(issue.imm);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
    end

    // broadcast payload
    always_ff @(posedge clock) begin
        cdb.value <= result;
        cdb.prn   <= issue.dest_prn;
        cdb.robn  <= issue.robn;
    end

endmodule

// ==== verilog/rob.sv ====
`timescale 1ns/1ps

module rob
    import ooo_isa_pkg::*, ooo_core_pkg::*;
#(
    parameter int ROB_SZ = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     disp_en,
    input  arn_t     disp_arn,
    input  prn_t     disp_prn,
    input  logic     disp_halt,
    output robn_t    tail,
    output logic     full,
    cdb_if.sink      cdb,
    retire_if.source retire,
    output logic     ct_halt
);

    localparam int CNT_W = $clog2(ROB_SZ + 1);

    rob_entry_t       entries [ROB_SZ];
    robn_t            head;
    logic [CNT_W-1:0] count;
    exc_e             status;
    logic             commit;

    function automatic robn_t next_ptr(robn_t p);
        return (p == robn_t'(ROB_SZ - 1)) ? '0 : p + 1'b1;
    endfunction

    // nothing commits once the halt is gone
    assign commit = (count != '0) && entries[head].complete && (status == NO_ERROR);
    assign full   = (count == CNT_W'(ROB_SZ));

    assign retire.valid = commit && !entries[head].halt;
    assign retire.arn   = entries[head].arn;
    assign retire.prn   = entries[head].prn;
    assign ct_halt      = commit && entries[head].halt;

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            status <= NO_ERROR;
        end else begin
            if (disp_en) begin
                tail <= next_ptr(tail);
            end
            if (commit) begin
                head <= next_ptr(head);
                if (entries[head].halt) begin
                    status <= HALTED;
                end
            end
            count <= count + CNT_W'(disp_en) - CNT_W'(commit);
        end
    end

    always_ff @(posedge clock) begin
        if (cdb.valid) begin
            entries[cdb.robn].complete <= 1'b1;
        end
        // halt never executes, so it is complete from the start
        if (disp_en) begin
            entries[tail] <= '{arn: disp_arn, prn: disp_prn,
                               complete: disp_halt, halt: disp_halt};
        end
    end

endmodule

// ==== verilog/ooo.sv ====
`timescale 1ns/1ps

module ooo
    import ooo_isa_pkg::*, ooo_core_pkg::*;
#(
    parameter int ROB_SZ = 8,
    parameter int RS_SZ  = 4
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  opcode_e in_op,
    input  arn_t    in_dest,
    input  arn_t    in_src1,
    input  arn_t    in_src2,
    input  imm_t    in_imm,
    output logic    stall,
    output logic    ct_valid,
    output arn_t    ct_arn,
    output data_t   ct_value,
    output logic    ct_halt
);

    issue_if  issue_bus ();
    cdb_if    cdb_bus ();
    retire_if retire_bus ();

    logic  accept;
    logic  is_halt;
    logic  is_li;
    logic  rename_en;
    prn_t  src1_prn;
    prn_t  src2_prn;
    prn_t  dest_prn;
    data_t rd_val1;
    data_t rd_val2;
    logic  rd_rdy1;
    logic  rd_rdy2;
    data_t opa_in;
    data_t opb_in;
    logic  rs_full;
    logic  rob_full;
    robn_t rob_tail;

    assign stall     = rs_full || rob_full;
    assign accept    = in_valid && !stall;
    assign is_halt   = (in_op == OP_HALT);
    assign is_li     = (in_op == OP_LI);
    // halt takes no register and skips the rs
    assign rename_en = accept && !is_halt;

    // ready operand carries its value, otherwise the producer tag
    assign opa_in = rd_rdy1 ? rd_val1 : data_t'(src1_prn);
    assign opb_in = rd_rdy2 ? rd_val2 : data_t'(src2_prn);

    rat rat_inst (
        .clock     (clock),
        .reset     (reset),
        .rename_en (rename_en),
        .src1      (in_src1),
        .src2      (in_src2),
        .dest      (in_dest),
        .src1_prn  (src1_prn),
        .src2_prn  (src2_prn),
        .dest_prn  (dest_prn),
        .retire    (retire_bus)
    );

    rrat rrat_inst (
        .clock  (clock),
        .reset  (reset),
        .retire (retire_bus)
    );

    prf prf_inst (
        .clock     (clock),
        .reset     (reset),
        .rd_prn1   (src1_prn),
        .rd_prn2   (src2_prn),
        .rd_val1   (rd_val1),
        .rd_val2   (rd_val2),
        .rd_rdy1   (rd_rdy1),
        .rd_rdy2   (rd_rdy2),
        .alloc_en  (rename_en),
        .alloc_prn (dest_prn),
        .cdb       (cdb_bus),
        .ct_prn    (retire_bus.prn),
        .ct_val    (ct_value)
    );

    // load-immediate reads no register
    rs #(
        .RS_SZ (RS_SZ)
    ) rs_inst (
        .clock       (clock),
        .reset       (reset),
        .in_en       (rename_en),
        .in_op       (in_op),
        .in_a        (opa_in),
        .in_b        (opb_in),
        .in_a_rdy    (rd_rdy1 || is_li),
        .in_b_rdy    (rd_rdy2 || is_li),
        .in_imm      (in_imm),
        .in_dest_prn (dest_prn),
        .in_robn     (rob_tail),
        .full        (rs_full),
        .cdb         (cdb_bus),
        .issue       (issue_bus)
    );

    alu_fu alu_inst (
        .clock (clock),
        .reset (reset),
        .issue (issue_bus),
        .cdb   (cdb_bus)
    );

    rob #(
        .ROB_SZ (ROB_SZ)
    ) rob_inst (
        .clock     (clock),
        .reset     (reset),
        .disp_en   (accept),
        .disp_arn  (in_dest),
        .disp_prn  (dest_prn),
        .disp_halt (is_halt),
        .tail      (rob_tail),
        .full      (rob_full),
        .cdb       (cdb_bus),
        .retire    (retire_bus),
        .ct_halt   (ct_halt)
    );

    assign ct_valid = retire_bus.valid || ct_halt;
    assign ct_arn   = retire_bus.arn;

endmodule

// ==== tests/ooo_tb.sv ====
`timescale 1ns/1ps

module ooo_tb
    import ooo_isa_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // random gaps only ahead of the opening instructions
    localparam int GAPPED       = 6;
    localparam int IDLE_CYCLES  = 20;

    logic    clock;
    logic    reset;
    logic    in_valid;
    opcode_e in_op;
    arn_t    in_dest;
    arn_t    in_src1;
    arn_t    in_src2;
    imm_t    in_imm;
    logic    stall;
    logic    ct_valid;
    arn_t    ct_arn;
    data_t   ct_value;
    logic    ct_halt;

    int    q_op [$];
    int    q_dest [$];
    int    q_src1 [$];
    int    q_src2 [$];
    int    q_imm [$];
    arn_t  exp_arn [$];
    data_t exp_value [$];
    bit    exp_halt [$];

    bit loaded;
    bit saw_stall;
    bit saw_halt;
    int n_commits;

    ooo #(
        .ROB_SZ (8),
        .RS_SZ  (4)
    ) uut (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_dest  (in_dest),
        .in_src1  (in_src1),
        .in_src2  (in_src2),
        .in_imm   (in_imm),
        .stall    (stall),
        .ct_valid (ct_valid),
        .ct_arn   (ct_arn),
        .ct_value (ct_value),
        .ct_halt  (ct_halt)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        stop_with_failure($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                                    $time, name, got, expected));
    endtask

    task automatic load_testdata();
        int    fd;
        int    n;
        int    f_op;
        int    f_dest;
        int    f_src1;
        int    f_src2;
        int    f_imm;
        byte   kind;
        string line;
        string rest;
        fd = $fopen("tests/ooo_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open tests/ooo_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) continue;
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (kind == "I") begin
                n = $sscanf(rest, "%d %d %d %d %h", f_op, f_dest, f_src1, f_src2, f_imm);
                assert (n == 5)
                    else stop_with_failure("malformed instruction line in testdata");
                q_op.push_back(f_op);
                q_dest.push_back(f_dest);
                q_src1.push_back(f_src1);
                q_src2.push_back(f_src2);
                q_imm.push_back(f_imm);
            end else if (kind == "C") begin
                n = $sscanf(rest, "%d %h", f_dest, f_imm);
                assert (n == 2)
                    else stop_with_failure("malformed commit line in testdata");
                exp_arn.push_back(arn_t'(f_dest));
                exp_value.push_back(data_t'(f_imm));
                exp_halt.push_back(1'b0);
            end else if (kind == "H") begin
                exp_arn.push_back('0);
                exp_value.push_back('0);
                exp_halt.push_back(1'b1);
            end
        end
        $fclose(fd);
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_instr(int i);
        in_valid = 1'b1;
        in_op    = opcode_e'(q_op[i]);
        in_dest  = arn_t'(q_dest[i]);
        in_src1  = arn_t'(q_src1[i]);
        in_src2  = arn_t'(q_src2[i]);
        in_imm   = imm_t'(q_imm[i]);
        // stall only moves on an edge, so mid-cycle tells acceptance
        @(negedge clock);
        while (stall) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    // commit checker samples mid-cycle where the outputs are settled
    always @(negedge clock) begin
        if (!reset && in_valid && stall) begin
            saw_stall = 1'b1;
        end
        if (!reset && ct_valid) begin
            assert (exp_halt.size() > 0)
                else stop_with_failure("a commit came after the halt had committed");
            if (exp_halt[0]) begin
                assert (ct_halt) else report_mismatch("ct_halt", ct_halt, 1);
            end else begin
                assert (!ct_halt) else report_mismatch("ct_halt", ct_halt, 0);
                assert (ct_arn == exp_arn[0])
                    else report_mismatch("ct_arn", ct_arn, exp_arn[0]);
                assert (ct_value == exp_value[0])
                    else report_mismatch("ct_value", ct_value, exp_value[0]);
            end
            void'(exp_arn.pop_front());
            void'(exp_value.pop_front());
            void'(exp_halt.pop_front());
            n_commits++;
            if (ct_halt) begin
                saw_halt = 1'b1;
            end
        end
    end

    initial begin
        wait (loaded);
        #((q_op.size() * 200 + RESET_CYCLES) * CLK_PERIOD);
        stop_with_failure("timeout, not every instruction committed in time");
    end

    initial begin
        int          gap;
        logic [31:0] rng;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = OP_ADD;
        in_dest   = '0;
        in_src1   = '0;
        in_src2   = '0;
        in_imm    = '0;
        saw_stall = 1'b0;
        saw_halt  = 1'b0;
        n_commits = 0;
        load_testdata();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        assert (!stall) else report_mismatch("stall", stall, 0);
        assert (!ct_valid) else report_mismatch("ct_valid", ct_valid, 0);
        assert (!ct_halt) else report_mismatch("ct_halt", ct_halt, 0);
        @(posedge clock);
        #1;

        rng = 32'd98;
        for (int i = 0; i < q_op.size(); i++) begin
            if (i < GAPPED) begin
                rng = xorshift(rng);
                gap = int'(rng % 4);
                in_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clock);
                    #1;
                end
            end
            send_instr(i);
        end
        in_valid = 1'b0;

        wait (saw_halt);
        // nothing may commit in the quiet window after the halt
        repeat (IDLE_CYCLES) @(posedge clock);
        assert (n_commits == q_op.size())
            else stop_with_failure($sformatf("%0d commits for %0d instructions",
                                             n_commits, q_op.size()));
        assert (saw_stall) else stop_with_failure("stall never rose during the burst");
        $display("No errors");
        $finish;
    end

endmodule

// ==== tests/ooo_testdata.txt ====
# I op dest src1 src2 imm(hex), op is 0 add 1 sub 2 and 3 or 4 xor 5 li 6 halt
# C arn value(hex) in commit order, H for the halt
I 5 1 0 0 8005
I 5 2 0 0 0003
I 0 3 1 2 0000
I 1 4 1 3 0000
I 4 5 4 3 0000
I 2 6 5 1 0000
I 0 1 1 1 0000
I 0 1 1 1 0000
I 0 1 1 1 0000
I 3 7 1 2 0000
I 0 1 1 7 0000
I 1 2 1 6 0000
I 0 1 1 1 0000
I 4 3 1 2 0000
I 0 0 3 1 0000
I 6 0 0 0 0000
C 1 00008005
C 2 00000003
C 3 00008008
C 4 fffffffd
C 5 ffff7ff5
C 6 00000005
C 1 0001000a
C 1 00020014
C 1 00040028
C 7 0004002b
C 1 00080053
C 2 0008004e
C 1 001000a6
C 3 001800e8
C 0 0028018e
H

// ==== filelist.f ====
common/ooo_isa_pkg.sv
common/ooo_core_pkg.sv
common/ooo_ifs.sv
rename/rat.sv
rename/rrat.sv
verilog/prf.sv
verilog/rs.sv
verilog/alu_fu.sv
verilog/rob.sv
verilog/ooo.sv
tests/ooo_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ooo_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "No errors" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
